// File: flist.f
source/asg_pkg.sv
source/asg_table.sv
source/asg_channel.sv
source/asg_regs.sv
source/asg_top.sv
test/asg_monitor.sv
test/asg_tb.sv

// File: Bender.yml
package:
  name: asg

sources:
  - files:
      - source/asg_pkg.sv
      - source/asg_table.sv
      - source/asg_channel.sv
      - source/asg_regs.sv
      - source/asg_top.sv
  - target: test
    files:
      - test/asg_monitor.sv
      - test/asg_tb.sv

// File: test/asg_tb.sv
// directed sequence with random table, config and stalls, fixed seed, 64 table words used
`timescale 1ns/1ps

module asg_tb;

  localparam int LIMIT = 20000;  // about four times the summed test lengths

  logic clk = 0, rstn = 0, trig_i = 0, sto_rdy = 0;
  logic bus_ena = 0, bus_wen = 0;
  logic [asg_pkg::BUS_AW-1:0] bus_addr = '0;
  logic [asg_pkg::BUS_DW-1:0] bus_wdata = '0, bus_rdata, rd;
  logic signed [asg_pkg::DWO-1:0] sto_dat;
  logic sto_vld, trig_o;
  logic rdy_rand = 0, rdy_hold = 1;  // stall pattern select
  logic [127:0] test_name = "reset";
  logic [31:0] seed = 32'hd31c_0a8a, val, rdly;
  logic signed [asg_pkg::DWO-1:0] tbl_w [64];
  int err_cnt = 0, err_mon, xfer_cnt, trig_cnt, pending, max_gap, cyc = 0, t0, x0;

  asg_top DUT (.clk, .rstn, .trig_i, .sto_dat, .sto_vld, .sto_rdy, .trig_o,
               .bus_ena, .bus_wen, .bus_addr, .bus_wdata, .bus_rdata);

  asg_monitor u_mon (.clk, .rstn, .bus_ena, .bus_wen, .bus_addr, .bus_wdata,
                     .sto_dat, .sto_vld, .sto_rdy, .trig_o, .test_name,
                     .err_cnt(err_mon), .xfer_cnt, .trig_cnt, .pending, .max_gap);

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // stall pattern, ready about 70%
  always @(negedge clk) sto_rdy <= rdy_rand ? ((lcg() >> 16) % 100 < 70) : rdy_hold;

  always @(posedge clk) begin
    cyc++;
    if (cyc >= LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cyc);
      $display("sim failed");
      $finish;
    end
  end

  task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
    @(negedge clk);
    {bus_ena, bus_wen, bus_addr, bus_wdata} = {2'b11, a, d};
    @(negedge clk);
    bus_ena = 0;
  endtask

  task automatic bus_read(input logic [15:0] a, output logic [31:0] d);
    @(negedge clk);
    {bus_ena, bus_wen, bus_addr} = {2'b10, a};
    @(negedge clk);
    bus_ena = 0;
    d = bus_rdata;  // one cycle after the read edge
  endtask

  task automatic expect_eq(input string what, input logic [31:0] e, input logic [31:0] a);
    if (e !== a) begin
      $display("FAIL %0s: %0s expected %0h actual %0h", test_name, what, e, a);
      err_cnt++;
    end
  endtask

  task automatic run_burst(input logic wrap, input logic zero);  // swtrig then wait for idle
    bus_write(16'(asg_pkg::REG_CTRL), {28'd0, zero, wrap, 2'b01});
    do bus_read(16'(asg_pkg::REG_CTRL), rd); while (rd[4]);
    expect_eq("pending samples", 0, pending);
  endtask

  task automatic set_cfg(input logic [31:0] step, offs, ncyc, rnum, dly);
    bus_write(16'(asg_pkg::REG_SIZE), (32'd64 << 16) - 1);  // 64 words
    bus_write(16'(asg_pkg::REG_STEP), step);
    bus_write(16'(asg_pkg::REG_OFFS), offs);
    bus_write(16'(asg_pkg::REG_NCYC), ncyc);
    bus_write(16'(asg_pkg::REG_RNUM), rnum);
    bus_write(16'(asg_pkg::REG_RDLY), dly);
  endtask

  initial begin
    repeat (10) @(posedge clk);
    @(negedge clk) rstn = 1;
    //////////////////////////////////////////////////
    expect_eq("sto_vld", 0, sto_vld);
    expect_eq("trig_o", 0, trig_o);
    bus_read(16'(asg_pkg::REG_STEP), rd);
    expect_eq("reset readback", 0, rd);
    test_name = "readback";
    for (int i = 0; i < 64; i++) begin
      tbl_w[i] = lcg() >> 18;
      bus_write(16'h8000 | 16'(i), 32'(tbl_w[i]));  // sign extended
      bus_read(16'h8000 | 16'(i), rd);
      expect_eq("table word", 32'(tbl_w[i]), rd);
    end
    for (int r = 1; r < 7; r++) begin
      val = lcg() & (r < 4 ? 32'h3fff_ffff : (r < 6 ? 32'hffff : 32'hffff_ffff));
      bus_write(16'(r), val);
      bus_read(16'(r), rd);
      expect_eq("config register", val, rd);
    end
    bus_write(16'(asg_pkg::REG_CTRL), 32'hc);  // zero and wrap levels, no trigger
    bus_read(16'(asg_pkg::REG_CTRL), rd);
    expect_eq("ctrl levels", 32'hc, rd);
    bus_write(16'(asg_pkg::REG_CTRL), 32'h0);
    //////////////////////////////////////////////////
    test_name = "single";
    set_cfg(32'h1_8000, (lcg() % 8) << 16, 3, 0, 0);
    t0 = trig_cnt;
    bus_write(16'(asg_pkg::REG_CTRL), 32'h1);
    wait (trig_cnt > t0);
    @(negedge clk) trig_i = 1;  // ignored while running
    bus_write(16'(asg_pkg::REG_CTRL), 32'h1);
    trig_i = 0;
    do bus_read(16'(asg_pkg::REG_CTRL), rd); while (rd[4]);
    expect_eq("pending samples", 0, pending);
    expect_eq("trig_o count", t0 + 1, trig_cnt);
    //////////////////////////////////////////////////
    test_name = "wrap";
    set_cfg(32'h2_4000 + (lcg() & 32'hfff), (lcg() % 8) << 16, 4, 0, 0);
    run_burst(1'b1, 1'b0);
    //////////////////////////////////////////////////
    test_name = "repeat";
    rdly = 20 + lcg() % 64;
    rdy_rand = 1;
    set_cfg(32'h1_4000, 32'h2_0000, 2, 2, rdly);
    t0 = trig_cnt;
    run_burst(1'b0, 1'b0);
    expect_eq("trig_o count", t0 + 1, trig_cnt);
    if (max_gap < rdly) begin
      $display("repeat: gap of %0d cycles between bursts is shorter than rdly %0d",
               max_gap, rdly);
      err_cnt++;
    end
    //////////////////////////////////////////////////
    test_name = "zero";
    x0 = xfer_cnt;
    set_cfg(32'h3_0000, 0, 2, 0, 0);
    run_burst(1'b0, 1'b1);
    if (xfer_cnt == x0) begin
      $display("zero: the burst delivered no samples");
      err_cnt++;
    end
    test_name = "abort";
    set_cfg(32'h0_c000, 0, 0, 0, 0);
    bus_write(16'(asg_pkg::REG_CTRL), 32'h1);
    wait (xfer_cnt > x0 + 300);
    @(negedge clk) begin
      rdy_rand = 0;
      rdy_hold = 0;
    end
    bus_write(16'(asg_pkg::REG_CTRL), 32'h2);
    x0 = xfer_cnt;
    @(negedge clk) rdy_hold = 1;
    repeat (50) @(negedge clk);
    expect_eq("transfers after abort", x0, xfer_cnt);
    bus_read(16'(asg_pkg::REG_CTRL), rd);
    expect_eq("running after abort", 0, rd[4]);
    //////////////////////////////////////////////////
    $display("errors: testbench %0d, monitor %0d", err_cnt, err_mon);
    if (err_cnt + err_mon == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: test/asg_monitor.sv
// model assumes the configuration is not rewritten while a burst runs and uses under 64 table words
`timescale 1ns/1ps

module asg_monitor (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           bus_ena,
  input  logic                           bus_wen,
  input  logic [asg_pkg::BUS_AW-1:0]     bus_addr,
  input  logic [asg_pkg::BUS_DW-1:0]     bus_wdata,
  input  logic signed [asg_pkg::DWO-1:0] sto_dat,
  input  logic                           sto_vld,
  input  logic                           sto_rdy,
  input  logic                           trig_o,
  input  logic [127:0]                   test_name,  // ascii label for error lines
  output int                             err_cnt,
  output int                             xfer_cnt,
  output int                             trig_cnt,
  output int                             pending,    // predicted samples not yet seen
  output int                             max_gap     // longest gap since the last trig_o
);

  logic signed [asg_pkg::DWO-1:0] tbl_m [2**asg_pkg::CWM];  // table copy
  logic [asg_pkg::PNT_W-1:0] size_m, step_m, offs_m;
  logic [15:0]               ncyc_m, rnum_m;
  logic                      wrap_m, zero_m;
  logic signed [asg_pkg::DWO-1:0] exp_q [$];  // predicted output stream
  int                        cyc, last_xfer;

  // one burst from offs, following the pointer rules
  task automatic gen_burst();
    logic [asg_pkg::PNT_W:0] p;
    logic [asg_pkg::PNT_W:0] nx;
    int                      left;
    int                      n;
    p    = {1'b0, offs_m};
    left = ncyc_m;
    n    = 0;
    forever begin
      exp_q.push_back(zero_m ? '0 : tbl_m[p[asg_pkg::CWF +: asg_pkg::CWM]]);
      n++;
      nx = p + {1'b0, step_m};
      if (nx > {1'b0, size_m}) begin
        if (left == 1) break;  // last period
        if (left > 1) left--;
        p = wrap_m ? nx - {1'b0, size_m} - 1 : {1'b0, offs_m};
      end else begin
        p = nx;
      end
      if (ncyc_m == 0 && n >= 3000) break;  // endless, cap the prediction
    end
  endtask

  assign pending = exp_q.size();

  always @(posedge clk) begin
    cyc++;
    if (!rstn) begin
      {size_m, step_m, offs_m, ncyc_m, rnum_m, wrap_m, zero_m} <= '0;
      exp_q.delete();
    end else begin
      // bus writes update the model
      if (bus_ena && bus_wen) begin
        if (bus_addr[asg_pkg::BUS_AW-1]) begin
          tbl_m[bus_addr[asg_pkg::CWM-1:0]] = bus_wdata[asg_pkg::DWO-1:0];
        end else begin
          case (bus_addr[2:0])
            asg_pkg::REG_CTRL: begin
              wrap_m = bus_wdata[2];
              zero_m = bus_wdata[3];
              if (bus_wdata[1]) exp_q.delete();  // sequencer reset drops the rest
            end
            asg_pkg::REG_SIZE: size_m = bus_wdata[asg_pkg::PNT_W-1:0];
            asg_pkg::REG_STEP: step_m = bus_wdata[asg_pkg::PNT_W-1:0];
            asg_pkg::REG_OFFS: offs_m = bus_wdata[asg_pkg::PNT_W-1:0];
            asg_pkg::REG_NCYC: ncyc_m = bus_wdata[15:0];
            asg_pkg::REG_RNUM: rnum_m = bus_wdata[15:0];
            default: ;
          endcase
        end
      end
      if (trig_o) begin  // accepted trigger, predict all bursts
        trig_cnt++;
        max_gap   = 0;
        last_xfer = -1;
        if (ncyc_m == 0) gen_burst();
        else for (int r = 0; r <= rnum_m; r++) gen_burst();
      end
      if (sto_vld && sto_rdy) begin
        if (last_xfer >= 0 && cyc - last_xfer > max_gap) max_gap = cyc - last_xfer;
        last_xfer = cyc;
        if (exp_q.size() == 0) begin
          $display("%0s: sample transfer with no sample predicted", test_name);
          err_cnt++;
        end else if (exp_q[0] !== sto_dat) begin
          $display("FAIL %0s: sample %0d expected %0d actual %0d",
                   test_name, xfer_cnt, exp_q[0], sto_dat);
          err_cnt++;
          void'(exp_q.pop_front());
        end else begin
          void'(exp_q.pop_front());
        end
        xfer_cnt++;
      end
    end
  end

  initial begin
    {err_cnt, xfer_cnt, trig_cnt, max_gap, cyc} = '0;
    last_xfer = -1;
  end

endmodule

// File: source/asg_top.sv
// one DAC channel, all inputs synchronous to clk, no bus handshake beyond strobes
`timescale 1ns/1ps

module asg_top (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           trig_i,
  // dac stream
  output logic signed [asg_pkg::DWO-1:0] sto_dat,
  output logic                           sto_vld,
  input  logic                           sto_rdy,
  output logic                           trig_o,
  // cpu bus
  input  logic                           bus_ena,
  input  logic                           bus_wen,
  input  logic [asg_pkg::BUS_AW-1:0]     bus_addr,
  input  logic [asg_pkg::BUS_DW-1:0]     bus_wdata,
  output logic [asg_pkg::BUS_DW-1:0]     bus_rdata
);

  //////////////////////////////////////////////////
  // regs to channel
  //////////////////////////////////////////////////

  asg_pkg::asg_cfg_t              cfg;
  asg_pkg::asg_tbl_req_t          tbl_req;
  logic                           trig;       // start pulse
  logic                           seq_rst;    // abort pulse
  logic signed [asg_pkg::DWO-1:0] tbl_rdata;  // cpu table readback
  logic                           running;

  asg_regs u_regs (
    .clk (clk), .rstn (rstn), .trig_i (trig_i),
    .bus_ena (bus_ena), .bus_wen (bus_wen), .bus_addr (bus_addr),
    .bus_wdata (bus_wdata), .bus_rdata (bus_rdata),
    .tbl_rdata (tbl_rdata), .running (running),
    .cfg (cfg), .trig (trig), .seq_rst (seq_rst), .tbl_req (tbl_req)
  );

  asg_channel u_channel (
    .clk (clk), .rstn (rstn),
    .cfg (cfg), .trig (trig), .seq_rst (seq_rst),
    .tbl_req (tbl_req), .tbl_rdata (tbl_rdata), .running (running),
    .trig_o (trig_o),
    .sto_dat (sto_dat), .sto_vld (sto_vld), .sto_rdy (sto_rdy)
  );

endmodule

// File: source/asg_regs.sv
// single cycle strobe bus only, reads return one cycle later and trig_i must be in the clk domain
`timescale 1ns/1ps

module asg_regs (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           trig_i,     // external trigger level
  // cpu bus
  input  logic                           bus_ena,
  input  logic                           bus_wen,
  input  logic [asg_pkg::BUS_AW-1:0]     bus_addr,
  input  logic [asg_pkg::BUS_DW-1:0]     bus_wdata,
  output logic [asg_pkg::BUS_DW-1:0]     bus_rdata,
  // from channel
  input  logic signed [asg_pkg::DWO-1:0] tbl_rdata,  // cpu port read data
  input  logic                           running,
  // to channel
  output asg_pkg::asg_cfg_t              cfg,
  output logic                           trig,       // start pulse
  output logic                           seq_rst,    // sequencer reset pulse
  output asg_pkg::asg_tbl_req_t          tbl_req
);

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  asg_pkg::asg_bus_word_u wr_word;   // incoming word, both views
  logic                   sel_tbl;   // table window
  logic                   reg_wr;    // register write strobe
  logic                   ctrl_wr;
  logic                   ext_edge;  // trig_i rising
  logic                   trig_q;    // trig_i one cycle old

  assign wr_word = bus_wdata;
  assign sel_tbl = bus_addr[asg_pkg::BUS_AW-1];
  assign reg_wr  = bus_ena & bus_wen & ~sel_tbl;
  assign ctrl_wr = reg_wr & (bus_addr[2:0] == asg_pkg::REG_CTRL);

  // table accesses pass straight to the channel memory
  assign tbl_req = '{
    ena:   bus_ena & sel_tbl,
    wen:   bus_wen,
    addr:  bus_addr[asg_pkg::CWM-1:0],
    wdata: wr_word.sample.smp
  };

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg <= '0;  // all levels idle
    end else if (reg_wr) begin
      case (bus_addr[2:0])
        asg_pkg::REG_CTRL: begin
          cfg.wrap <= wr_word.ctrl.wrap;
          cfg.zero <= wr_word.ctrl.zero;
        end
        asg_pkg::REG_SIZE: cfg.size <= bus_wdata[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_STEP: cfg.step <= bus_wdata[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_OFFS: cfg.offs <= bus_wdata[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_NCYC: cfg.ncyc <= bus_wdata[15:0];
        asg_pkg::REG_RNUM: cfg.rnum <= bus_wdata[15:0];
        asg_pkg::REG_RDLY: cfg.rdly <= bus_wdata;
        default: ;  // index 7 ignores writes
      endcase
    end
  end

  //////////////////////////////////////////////////
  // trigger and reset pulses
  //////////////////////////////////////////////////

  assign ext_edge = trig_i & ~trig_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      trig_q  <= 1'b0;
      trig    <= 1'b0;
      seq_rst <= 1'b0;
    end else begin
      trig_q  <= trig_i;
      // back to back requests merge into one pulse
      trig    <= (ext_edge | (ctrl_wr & wr_word.ctrl.swtrig)) & ~trig;
      seq_rst <= ctrl_wr & wr_word.ctrl.rst & ~seq_rst;
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  asg_pkg::asg_bus_word_u ctrl_word;  // status view of CTRL
  asg_pkg::asg_bus_word_u tbl_word;   // sign extended sample
  logic [asg_pkg::BUS_DW-1:0] reg_val;
  logic [asg_pkg::BUS_DW-1:0] reg_q;  // register value of last read
  logic                       tbl_q;  // last read hit the table

  always_comb begin
    ctrl_word              = '0;
    ctrl_word.ctrl.running = running;
    ctrl_word.ctrl.zero    = cfg.zero;
    ctrl_word.ctrl.wrap    = cfg.wrap;
    tbl_word.sample.pad    = {(asg_pkg::BUS_DW-asg_pkg::DWO){tbl_rdata[asg_pkg::DWO-1]}};
    tbl_word.sample.smp    = tbl_rdata;
    case (bus_addr[2:0])
      asg_pkg::REG_CTRL: reg_val = ctrl_word;
      asg_pkg::REG_SIZE: reg_val = 32'(cfg.size);
      asg_pkg::REG_STEP: reg_val = 32'(cfg.step);
      asg_pkg::REG_OFFS: reg_val = 32'(cfg.offs);
      asg_pkg::REG_NCYC: reg_val = 32'(cfg.ncyc);
      asg_pkg::REG_RNUM: reg_val = 32'(cfg.rnum);
      asg_pkg::REG_RDLY: reg_val = cfg.rdly;
      default:           reg_val = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tbl_q <= 1'b0;
      reg_q <= '0;
    end else if (bus_ena & ~bus_wen) begin
      tbl_q <= sel_tbl;
      reg_q <= reg_val;
    end
  end

  // table data comes registered from the memory
  assign bus_rdata = tbl_q ? tbl_word : reg_q;

  // pulses reach the channel as single cycles
  a_trig_pulse: assert property (@(posedge clk) disable iff (!rstn) trig |=> !trig);
  a_rst_pulse:  assert property (@(posedge clk) disable iff (!rstn) seq_rst |=> !seq_rst);

endmodule

// File: source/asg_channel.sv
// zero and wrap are expected static during a burst, size must stay below the table depth
`timescale 1ns/1ps

module asg_channel (
  input  logic                           clk,
  input  logic                           rstn,
  input  asg_pkg::asg_cfg_t              cfg,
  input  logic                           trig,       // start pulse
  input  logic                           seq_rst,    // abort pulse
  input  asg_pkg::asg_tbl_req_t          tbl_req,
  output logic signed [asg_pkg::DWO-1:0] tbl_rdata,
  output logic                           running,    // burst, delay or samples in flight
  output logic                           trig_o,
  // dac stream
  output logic signed [asg_pkg::DWO-1:0] sto_dat,
  output logic                           sto_vld,
  input  logic                           sto_rdy
);

  //////////////////////////////////////////////////
  // sample memory
  //////////////////////////////////////////////////

  logic [asg_pkg::PNT_W-1:0]      pnt;      // fixed point read pointer
  logic                           rd_en;    // stage advance
  logic signed [asg_pkg::DWO-1:0] rd_data;
  logic                           s1_vld;   // address stage holds a sample
  logic                           s2_vld;   // data stage holds a sample

  asg_table u_table (
    .clk       (clk),
    .tbl_req   (tbl_req),
    .tbl_rdata (tbl_rdata),
    .rd_en     (rd_en),
    .rd_addr   (pnt[asg_pkg::CWF +: asg_pkg::CWM]),
    .rd_data   (rd_data)
  );

  // move unless the output stage is full and blocked
  assign rd_en = ~s2_vld | sto_rdy;

  //////////////////////////////////////////////////
  // pointer arithmetic
  //////////////////////////////////////////////////

  logic [asg_pkg::PNT_W:0] nxt;      // one extra bit for overflow
  logic [asg_pkg::PNT_W:0] nxt_sub;  // wrapped remainder
  logic                    period_end;

  assign nxt        = {1'b0, pnt} + {1'b0, cfg.step};
  assign period_end = nxt > {1'b0, cfg.size};
  assign nxt_sub    = nxt - {1'b0, cfg.size} - 1'b1;

  //////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////

  logic        do_burst;  // pointer walking the table
  logic        in_delay;  // gap between repetitions
  logic [15:0] cyc_cnt;   // periods left, 0 endless
  logic [15:0] rep_cnt;   // bursts left after this one
  logic [31:0] dly_cnt;
  logic        adv;       // pointer steps this cycle

  assign running = do_burst | in_delay | s1_vld | s2_vld;
  assign adv     = do_burst & rd_en;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      do_burst <= 1'b0;
      in_delay <= 1'b0;
      s1_vld   <= 1'b0;
      s2_vld   <= 1'b0;
      pnt      <= '0;
      cyc_cnt  <= '0;
      rep_cnt  <= '0;
      dly_cnt  <= '0;
    end else if (seq_rst) begin
      do_burst <= 1'b0;  // abort and flush
      in_delay <= 1'b0;
      s1_vld   <= 1'b0;
      s2_vld   <= 1'b0;
    end else begin
      if (rd_en) begin
        s2_vld <= s1_vld;
        s1_vld <= do_burst;  // current pointer enters stage 1
      end
      if (trig && !running) begin
        do_burst <= 1'b1;
        pnt      <= cfg.offs;
        cyc_cnt  <= cfg.ncyc;
        rep_cnt  <= cfg.rnum;
      end else if (adv) begin
        if (period_end) begin
          pnt <= cfg.wrap ? nxt_sub[asg_pkg::PNT_W-1:0] : cfg.offs;
          if (cyc_cnt == 16'd1) begin  // last period done
            do_burst <= 1'b0;
            in_delay <= |rep_cnt;
            dly_cnt  <= cfg.rdly;
          end
          if (cyc_cnt > 16'd1) cyc_cnt <= cyc_cnt - 16'd1;  // 0 stays endless
        end else begin
          pnt <= nxt[asg_pkg::PNT_W-1:0];
        end
      end else if (in_delay) begin
        if (dly_cnt == '0) begin  // restart, no trig_o
          in_delay <= 1'b0;
          do_burst <= 1'b1;
          rep_cnt  <= rep_cnt - 16'd1;
          pnt      <= cfg.offs;
          cyc_cnt  <= cfg.ncyc;
        end else begin
          dly_cnt <= dly_cnt - 32'd1;
        end
      end
    end
  end

  // only a trigger taken from idle is echoed
  always_ff @(posedge clk) begin
    if (!rstn) trig_o <= 1'b0;
    else       trig_o <= trig & ~running & ~seq_rst;
  end

  //////////////////////////////////////////////////
  // dac output
  //////////////////////////////////////////////////

  assign sto_vld = s2_vld;
  assign sto_dat = cfg.zero ? '0 : rd_data;  // same count and timing when zeroed

  // held sample must not change under backpressure
  a_hold: assert property (@(posedge clk) disable iff (!rstn)
    (sto_vld && !sto_rdy && !seq_rst) |=> $stable(sto_dat));

  // reset flushes both stages at once
  a_flush: assert property (@(posedge clk) disable iff (!rstn) seq_rst |=> !sto_vld);

endmodule

// File: source/asg_table.sv
// sample memory has no reset, contents are undefined until the CPU writes them
`timescale 1ns/1ps

module asg_table (
  input  logic                           clk,
  // cpu port
  input  asg_pkg::asg_tbl_req_t          tbl_req,
  output logic signed [asg_pkg::DWO-1:0] tbl_rdata,  // valid one cycle after a read
  // stream port
  input  logic                           rd_en,      // pipeline advance
  input  logic [asg_pkg::CWM-1:0]        rd_addr,    // pointer integer part
  output logic signed [asg_pkg::DWO-1:0] rd_data     // two stages behind rd_addr
);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  logic signed [asg_pkg::DWO-1:0] mem [2**asg_pkg::CWM];

  logic [asg_pkg::CWM-1:0] addr_q;  // stage 1 address

  //////////////////////////////////////////////////
  // cpu port
  //////////////////////////////////////////////////

  // write or read in one cycle
  always_ff @(posedge clk) begin
    if (tbl_req.ena) begin
      if (tbl_req.wen) begin
        mem[tbl_req.addr] <= tbl_req.wdata;
      end else begin
        tbl_rdata <= mem[tbl_req.addr];
      end
    end
  end

  //////////////////////////////////////////////////
  // stream port
  //////////////////////////////////////////////////

  // both stages hold while the DAC stalls
  always_ff @(posedge clk) begin
    if (rd_en) begin
      addr_q  <= rd_addr;      // stage 1
      rd_data <= mem[addr_q];  // stage 2
    end
  end

  // same cycle write and stream read of one word returns the old sample

endmodule

// File: source/asg_pkg.sv
// widths are fixed here for one 14 bit DAC channel and a 32 bit CPU bus with word addressing

package asg_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned DWO    = 14;         // sample width at the DAC
  localparam int unsigned CWM    = 14;         // table address, pointer integer part
  localparam int unsigned CWF    = 16;         // pointer fraction
  localparam int unsigned PNT_W  = CWM + CWF;  // full fixed point pointer
  localparam int unsigned BUS_AW = 16;         // bus word address
  localparam int unsigned BUS_DW = 32;         // bus data word

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  // bus_addr[BUS_AW-1] set selects the sample table
  // otherwise bus_addr[2:0] picks one of these
  localparam logic [2:0] REG_CTRL = 3'd0;  // running, zero, wrap, rst, swtrig
  localparam logic [2:0] REG_SIZE = 3'd1;  // table size minus one, fixed point
  localparam logic [2:0] REG_STEP = 3'd2;  // pointer step, fixed point
  localparam logic [2:0] REG_OFFS = 3'd3;  // start offset, fixed point
  localparam logic [2:0] REG_NCYC = 3'd4;  // periods per burst, 0 is endless
  localparam logic [2:0] REG_RNUM = 3'd5;  // extra bursts after the first
  localparam logic [2:0] REG_RDLY = 3'd6;  // idle cycles between bursts
  // index 7 is unmapped and reads zero

  //////////////////////////////////////////////////
  // bus word, two ways to read the same 32 bits
  //////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      logic        [BUS_DW-DWO-1:0] pad;  // sign fill on readback
      logic signed [DWO-1:0]        smp;  // table sample
    } sample;
    struct packed {
      logic [BUS_DW-5-1:0] pad;
      logic                running;  // read only
      logic                zero;     // force DAC to zero
      logic                wrap;     // carry fraction across table end
      logic                rst;      // sequencer reset, self clearing
      logic                swtrig;   // software trigger, self clearing
    } ctrl;
  } asg_bus_word_u;

  //////////////////////////////////////////////////
  // configuration and table request
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [PNT_W-1:0] size;  // last valid pointer value
    logic [PNT_W-1:0] step;
    logic [PNT_W-1:0] offs;
    logic [15:0]      ncyc;
    logic [15:0]      rnum;
    logic [31:0]      rdly;
    logic             wrap;  // level
    logic             zero;  // level
  } asg_cfg_t;

  typedef struct packed {
    logic                  ena;    // table access this cycle
    logic                  wen;    // write when set, else read
    logic [CWM-1:0]        addr;
    logic signed [DWO-1:0] wdata;
  } asg_tbl_req_t;

endpackage
